// ==== sources.f ====
source/oadc_pkg.sv
source/oadc_timebase.sv
source/extclk_monitor.sv
source/oadc_regs.sv
source/oadc_top.sv
tb/oadc_checker.sv
tb/oadc_assert.sv
tb/tb_oadc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_oadc -f sources.f -o tb_oadc \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_oadc > sim.log 2>&1 ; cat sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tb/oadc_patterns.txt ====
# name kind addr(hex) bytecnt(hex) data(hex) extclk_period(dec, 0 keeps last) expected(hex)
# kinds: wr, rd (one byte), freq (wait data windows, read 4 bytes), wait (data windows),
#        pwm (write, count highs), led (write, sample {armed,capture}), ledeq (armed==capture)
gain_wr      wr    11 0 5a 0 0
limit_wr0    wr    12 0 78 0 0
limit_wr1    wr    12 1 56 0 0
limit_wr2    wr    12 2 34 0 0
limit_wr3    wr    12 3 12 0 0
gain_rd      rd    11 0 0  0 5a
limit_rd0    rd    12 0 0  0 78
limit_rd1    rd    12 1 0  0 56
limit_rd2    rd    12 2 0  0 34
limit_rd3    rd    12 3 0  0 12
limit_rd4    rd    12 4 0  0 0
unmapped_rd  rd    3f 0 0  0 0
freq_p4      freq  13 0 3  4 40
freq_p5      freq  13 0 3  5 33
freq_p8      freq  13 0 3  8 20
pwm_g64      pwm   11 0 40 0 40
pwm_g3       pwm   11 0 03 0 3
pwm_g0       pwm   11 0 00 0 0
led_lamp     led   10 0 07 0 3
led_dark     led   10 0 06 0 0
limit_set0   wr    12 0 04 4 0
limit_set1   wr    12 1 00 0 0
limit_set2   wr    12 2 00 0 0
limit_set3   wr    12 3 00 0 0
settle       wait  00 0 2  0 0
monitor_on   wr    10 0 00 0 0
steady_wait  wait  00 0 2  0 0
steady_st    rd    14 0 0  0 0
slow_wait    wait  00 0 2  8 0
change_st    rd    14 0 0  0 1
flash_leds   ledeq 00 0 0  0 0
monitor_off  wr    10 0 04 0 0
disabled_st  rd    14 0 0  0 2

// ==== tb/tb_oadc.sv ====
`default_nettype none

module tb_oadc;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int GATE_LOG2 = 8;
   localparam int WIN       = 1 << GATE_LOG2;   // clk_usb cycles per gate window
   localparam int MAX_REC   = 64;

   logic                clk_usb;
   logic                reset;
   oadc_pkg::reg_bus_t  reg_bus;
   oadc_pkg::reg_byte_t reg_datao;
   logic                extclk;
   logic                led_armed;
   logic                led_capture;
   logic                amp_gain;

   // pattern records
   string       rec_name   [MAX_REC];
   string       rec_kind   [MAX_REC];
   logic [31:0] rec_addr   [MAX_REC];
   logic [31:0] rec_cnt    [MAX_REC];
   logic [31:0] rec_data   [MAX_REC];
   int          rec_period [MAX_REC];
   logic [31:0] rec_exp    [MAX_REC];
   int          n_rec = 0;
   int          pattern_errors = 0;

   int ext_period = 0;    // target clock period in clk_usb cycles, below 2 holds it low
   int ext_phase = 0;
   int cycle_cnt = 0;
   int cycle_limit = 0;

   oadc_top #(
      .P_GATE_LOG2 (GATE_LOG2)
   ) dut (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_bus_i     (reg_bus),
      .reg_datao_o   (reg_datao),
      .extclk_i      (extclk),
      .led_armed_o   (led_armed),
      .led_capture_o (led_capture),
      .amp_gain_o    (amp_gain)
   );

   oadc_checker u_checker (
      .clk_usb       (clk_usb),
      .reg_datao_i   (reg_datao),
      .led_armed_i   (led_armed),
      .led_capture_i (led_capture),
      .amp_gain_i    (amp_gain)
   );

   always #4 clk_usb = ~clk_usb;

   // target clock, high for the first half of each period
   always @(posedge clk_usb) begin
      #1;
      if (ext_period < 2) begin
         ext_phase = 0;
         extclk    = 1'b0;
      end else begin
         if (ext_phase >= ext_period - 1)
            ext_phase = 0;
         else
            ext_phase = ext_phase + 1;
         extclk = (ext_phase < ext_period / 2);
      end
   end

   always @(posedge clk_usb) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
         $display("Test FAILED");
         $finish;
      end
   end

   function automatic int record_cycles(input string kind, input logic [31:0] data);
      int n;
      n = 4;   // bus access plus slack
      if (kind == "freq" || kind == "wait")
         n = n + int'(data) * WIN;
      else if (kind == "pwm")
         n = n + 16 + 256;
      else if (kind == "ledeq")
         n = n + 64;
      return n;
   endfunction

   task automatic load_patterns();
      int          fd;
      int          n;
      string       line;
      string       nm;
      string       kd;
      logic [31:0] a, c, d, e;
      int          p;
      fd = $fopen("tb/oadc_patterns.txt", "r");
      if (fd == 0) begin
         $display("cannot open the pattern file tb/oadc_patterns.txt");
         pattern_errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != 8'h23) begin   // skip # lines
               n = $sscanf(line, "%s %s %h %h %h %d %h", nm, kd, a, c, d, p, e);
               if (n == 7 && n_rec < MAX_REC) begin
                  rec_name[n_rec]   = nm;
                  rec_kind[n_rec]   = kd;
                  rec_addr[n_rec]   = a;
                  rec_cnt[n_rec]    = c;
                  rec_data[n_rec]   = d;
                  rec_period[n_rec] = p;
                  rec_exp[n_rec]    = e;
                  n_rec++;
               end else begin
                  $display("pattern line could not be used: %s", line);
                  pattern_errors++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic bus_write(input logic [31:0] a, input logic [31:0] c, input logic [31:0] d);
      @(posedge clk_usb);
      #1;
      reg_bus = '{address: a[7:0], bytecnt: c[6:0], data: d[7:0], read: 1'b0, write: 1'b1};
      @(posedge clk_usb);
      #1;
      reg_bus = '0;
   endtask

   task automatic bus_read(input logic [31:0] a, input logic [31:0] c, input int idx);
      @(posedge clk_usb);
      #1;
      reg_bus = '{address: a[7:0], bytecnt: c[6:0], data: 8'h00, read: 1'b1, write: 1'b0};
      u_checker.capture_byte(idx);
      @(posedge clk_usb);
      #1;
      reg_bus = '0;
   endtask

   task automatic run_record(input int i);
      if (rec_period[i] != 0)
         ext_period = rec_period[i];
      if (rec_kind[i] == "wr") begin
         bus_write(rec_addr[i], rec_cnt[i], rec_data[i]);
      end else if (rec_kind[i] == "rd") begin
         bus_read(rec_addr[i], rec_cnt[i], 0);
         u_checker.check_word(rec_name[i], rec_exp[i], 0);
      end else if (rec_kind[i] == "freq") begin
         repeat (int'(rec_data[i]) * WIN) @(posedge clk_usb);
         for (int b = 0; b < 4; b++)
            bus_read(rec_addr[i], 32'(b), b);
         u_checker.check_word(rec_name[i], rec_exp[i], 1);   // gate phase costs one edge
      end else if (rec_kind[i] == "wait") begin
         repeat (int'(rec_data[i]) * WIN) @(posedge clk_usb);
      end else if (rec_kind[i] == "pwm") begin
         bus_write(rec_addr[i], rec_cnt[i], rec_data[i]);
         repeat (16) @(posedge clk_usb);
         u_checker.check_pwm(rec_name[i], rec_exp[i]);
      end else if (rec_kind[i] == "led") begin
         bus_write(rec_addr[i], rec_cnt[i], rec_data[i]);
         u_checker.check_leds(rec_name[i], rec_exp[i]);
      end else if (rec_kind[i] == "ledeq") begin
         u_checker.check_led_match(rec_name[i]);
      end else begin
         $display("record %s has an unknown kind %s", rec_name[i], rec_kind[i]);
         pattern_errors++;
      end
   endtask

   initial begin
      int total;
      clk_usb = 1'b0;
      reset   = 1'b1;
      reg_bus = '0;
      extclk  = 1'b0;
      load_patterns();
      total = 4;
      for (int i = 0; i < n_rec; i++)
         total = total + record_cycles(rec_kind[i], rec_data[i]);
      cycle_limit = 2 * total;
      repeat (4) @(posedge clk_usb);
      #1;
      reset = 1'b0;
      for (int i = 0; i < n_rec; i++)
         run_record(i);
      u_checker.print_summary();
      if (u_checker.fail_cnt == 0 && pattern_errors == 0 && n_rec > 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/oadc_assert.sv ====
`default_nettype none

module oadc_assert (
   input wire                      clk_usb,
   input wire                      reset,
   input wire oadc_pkg::reg_bus_t  reg_bus_i,
   input wire oadc_pkg::reg_byte_t reg_datao_i,
   input wire                      led_armed_i,
   input wire                      led_capture_i,
   input wire                      amp_gain_i,
   input wire oadc_pkg::gain_t     gain_i,
   input wire oadc_pkg::led_sel_e  led_sel_i,
   input wire                      change_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // a zero increment cannot carry out of the accumulator
   gain_zero_quiet: assert property (@(posedge clk_usb) disable iff (reset)
      gain_i == '0 |=> !amp_gain_i)
      else $error("amp_gain_o pulsed while the gain register is zero");

   led_off_dark: assert property (@(posedge clk_usb) disable iff (reset)
      (led_sel_i == oadc_pkg::led_off && !change_i) |-> (!led_armed_i && !led_capture_i))
      else $error("an LED is lit although the source is led_off");

   read_known: assert property (@(posedge clk_usb) disable iff (reset)
      reg_bus_i.read |-> !$isunknown(reg_datao_i))
      else $error("readback carries unknown bits during a read");

endmodule

bind oadc_top oadc_assert u_assert (
   .clk_usb       (clk_usb),
   .reset         (reset),
   .reg_bus_i     (reg_bus_i),
   .reg_datao_i   (reg_datao_o),
   .led_armed_i   (led_armed_o),
   .led_capture_i (led_capture_o),
   .amp_gain_i    (amp_gain_o),
   .gain_i        (u_regs.gain_q),
   .led_sel_i     (u_regs.led_sel_q),
   .change_i      (extclk_stat.change)
);

`default_nettype wire

// ==== tb/oadc_checker.sv ====
`default_nettype none

module oadc_checker (
   input wire                      clk_usb,
   input wire oadc_pkg::reg_byte_t reg_datao_i,
   input wire                      led_armed_i,
   input wire                      led_capture_i,
   input wire                      amp_gain_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int          pass_cnt = 0;
   int          fail_cnt = 0;
   logic [31:0] word_acc = '0;   // bytes gathered from the read port

   task automatic log_result(input string name, input bit ok,
                             input logic [31:0] exp, input logic [31:0] act);
      if (ok) begin
         pass_cnt++;
         $display("ok   %s value %0h", name, act);
      end else begin
         fail_cnt++;
         $display("ERR  %s expected %0h actual %0h", name, exp, act);
      end
   endtask

   // readback is sampled mid cycle, after the bus settled
   task automatic capture_byte(input int idx);
      @(negedge clk_usb);
      if (idx == 0)
         word_acc = '0;
      word_acc[8*idx +: 8] = reg_datao_i;
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input int tol);
      longint diff;
      diff = longint'(word_acc) - longint'(exp);
      if (diff < 0)
         diff = -diff;
      log_result(name, diff <= longint'(tol), exp, word_acc);
   endtask

   // carries seen over one full accumulator cycle
   task automatic check_pwm(input string name, input logic [31:0] exp);
      int highs;
      highs = 0;
      repeat (256) begin
         @(negedge clk_usb);
         if (amp_gain_i)
            highs++;
      end
      log_result(name, highs == int'(exp), exp, 32'(highs));
   endtask

   task automatic check_leds(input string name, input logic [31:0] exp);
      logic [31:0] act;
      @(negedge clk_usb);
      act = {30'b0, led_armed_i, led_capture_i};
      log_result(name, act == exp, exp, act);
   endtask

   // both LEDs must follow the same source, expects zero mismatches
   task automatic check_led_match(input string name);
      int mism;
      mism = 0;
      repeat (64) begin
         @(negedge clk_usb);
         if (led_armed_i != led_capture_i)
            mism++;
      end
      log_result(name, mism == 0, 32'd0, 32'(mism));
   endtask

   task automatic print_summary();
      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
   endtask

endmodule

`default_nettype wire

// ==== source/oadc_top.sv ====
`default_nettype none

module oadc_top #(
   parameter int P_GATE_LOG2 = 23          // gate window is 2**P_GATE_LOG2 cycles
)(
   input  wire                          clk_usb,
   input  wire                          reset,

   // host register bus
   input  wire oadc_pkg::reg_bus_t      reg_bus_i,
   output wire oadc_pkg::reg_byte_t     reg_datao_o,

   input  wire                          extclk_i,   // target clock, async

   output wire                          led_armed_o,
   output wire                          led_capture_o,
   output wire                          amp_gain_o
);

   oadc_pkg::timebase_t    tb;
   oadc_pkg::extclk_stat_t extclk_stat;
   logic                   monitor_disable;
   oadc_pkg::freq_count_t  extclk_limit;

   oadc_timebase #(
      .P_GATE_LOG2 (P_GATE_LOG2)
   ) u_timebase (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .tb_o        (tb)
   );

   extclk_monitor u_extclk_monitor (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .tb_i              (tb),
      .extclk_i          (extclk_i),
      .monitor_disable_i (monitor_disable),
      .limit_i           (extclk_limit),
      .stat_o            (extclk_stat)
   );

   // settings go back to the monitor, results come out to the pins
   oadc_regs u_regs (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .bus_i             (reg_bus_i),
      .reg_datao_o       (reg_datao_o),
      .tb_i              (tb),
      .stat_i            (extclk_stat),
      .monitor_disable_o (monitor_disable),
      .limit_o           (extclk_limit),
      .led_armed_o       (led_armed_o),
      .led_capture_o     (led_capture_o),
      .amp_gain_o        (amp_gain_o)
   );

endmodule

`default_nettype wire

// ==== source/oadc_regs.sv ====
`default_nettype none

module oadc_regs (
   input  wire                         clk_usb,
   input  wire                         reset,
   input  wire oadc_pkg::reg_bus_t     bus_i,
   output oadc_pkg::reg_byte_t         reg_datao_o,
   input  wire oadc_pkg::timebase_t    tb_i,
   input  wire oadc_pkg::extclk_stat_t stat_i,
   output logic                        monitor_disable_o,
   output oadc_pkg::freq_count_t       limit_o,
   output logic                        led_armed_o,
   output logic                        led_capture_o,
   output logic                        amp_gain_o
);

   oadc_pkg::led_sel_e    led_sel_q;
   logic                  mon_dis_q;
   oadc_pkg::gain_t       gain_q;
   oadc_pkg::freq_count_t limit_q;
   logic [8:0]            pwm_acc;     // bit 8 is the carry out

   // picks one byte of a 32-bit register, zero past byte 3
   function automatic oadc_pkg::reg_byte_t word_byte(input logic [31:0] word,
                                                     input oadc_pkg::reg_bytecnt_t idx);
      oadc_pkg::reg_byte_t b;
      b = '0;
      if (idx < 7'd4)
         b = word[idx[1:0]*8 +: 8];
      return b;
   endfunction

   // host writes
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         led_sel_q <= oadc_pkg::led_normal;
         mon_dis_q <= 1'b1;       // no false change from the first window
         gain_q    <= '0;
         limit_q   <= '0;
      end else if (bus_i.write) begin
         case (bus_i.address)
            oadc_pkg::ADDR_LED_SELECT: begin
               if (bus_i.bytecnt == '0) begin
                  led_sel_q <= oadc_pkg::led_sel_e'(bus_i.data[1:0]);
                  mon_dis_q <= bus_i.data[2];
               end
            end
            oadc_pkg::ADDR_GAIN: begin
               if (bus_i.bytecnt == '0)
                  gain_q <= bus_i.data;
            end
            oadc_pkg::ADDR_EXTCLK_LIMIT: begin
               if (bus_i.bytecnt < 7'd4)
                  limit_q[bus_i.bytecnt[1:0]*8 +: 8] <= bus_i.data;   // LSB first
            end
            default: ;   // read-only and unmapped addresses ignore writes
         endcase
      end
   end

   // readback, combinational
   always_comb begin
      reg_datao_o = '0;
      if (bus_i.read) begin
         case (bus_i.address)
            oadc_pkg::ADDR_LED_SELECT: begin
               if (bus_i.bytecnt == '0)
                  reg_datao_o = {5'b0, mon_dis_q, led_sel_q};
            end
            oadc_pkg::ADDR_GAIN: begin
               if (bus_i.bytecnt == '0)
                  reg_datao_o = gain_q;
            end
            oadc_pkg::ADDR_EXTCLK_LIMIT: reg_datao_o = word_byte(limit_q, bus_i.bytecnt);
            oadc_pkg::ADDR_EXTCLK_FREQ:  reg_datao_o = word_byte(stat_i.frequency, bus_i.bytecnt);
            oadc_pkg::ADDR_STATUS: begin
               if (bus_i.bytecnt == '0)
                  reg_datao_o = {6'b0, mon_dis_q, stat_i.change};
            end
            default: reg_datao_o = '0;
         endcase
      end
   end

   // LED source, a detected change overrides everything
   always_comb begin
      if (stat_i.change) begin
         led_armed_o   = tb_i.flash;
         led_capture_o = tb_i.flash;
      end else begin
         case (led_sel_q)
            oadc_pkg::led_normal: begin
               led_armed_o   = tb_i.heartbeat;
               led_capture_o = stat_i.change;
            end
            oadc_pkg::led_extclk: begin
               led_armed_o   = stat_i.clk_level;
               led_capture_o = stat_i.clk_level;
            end
            oadc_pkg::led_off: begin
               led_armed_o   = 1'b0;
               led_capture_o = 1'b0;
            end
            default: begin   // lamp test
               led_armed_o   = 1'b1;
               led_capture_o = 1'b1;
            end
         endcase
      end
   end

   // first order PWM, the carry fires gain times per 256 cycles
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain_q};
   end

   assign amp_gain_o        = pwm_acc[8];
   assign monitor_disable_o = mon_dis_q;
   assign limit_o           = limit_q;

endmodule

`default_nettype wire

// ==== source/extclk_monitor.sv ====
`default_nettype none

module extclk_monitor (
   input  wire                    clk_usb,
   input  wire                    reset,
   input  wire oadc_pkg::timebase_t tb_i,
   input  wire                    extclk_i,
   input  wire                    monitor_disable_i,
   input  wire oadc_pkg::freq_count_t limit_i,
   output oadc_pkg::extclk_stat_t stat_o
);

   logic                  ext_meta;     // first synchroniser stage
   logic                  ext_sync;     // second stage, safe to use
   logic                  ext_prev;     // for edge detection
   logic                  ext_rise;

   oadc_pkg::freq_count_t edge_cnt;     // edges in the running window
   oadc_pkg::freq_count_t freq_q;       // count of the last full window
   oadc_pkg::freq_count_t freq_diff;
   logic                  over_limit;
   logic                  change_q;

   // target clock is asynchronous to clk_usb
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_meta <= 1'b0;
         ext_sync <= 1'b0;
         ext_prev <= 1'b0;
      end else begin
         ext_meta <= extclk_i;
         ext_sync <= ext_meta;
         ext_prev <= ext_sync;
      end
   end

   assign ext_rise = ext_sync & ~ext_prev;

   // distance between the new count and the last latched one
   always_comb begin
      if (freq_q > edge_cnt)
         freq_diff = freq_q - edge_cnt;
      else
         freq_diff = edge_cnt - freq_q;
   end

   assign over_limit = (edge_cnt != '0) && (freq_diff > limit_i);

   // window count and latch
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         edge_cnt <= '0;
         freq_q   <= '0;
      end else if (tb_i.gate_pulse) begin
         freq_q   <= edge_cnt;
         edge_cnt <= oadc_pkg::freq_count_t'(ext_rise);   // edge in this cycle opens the new window
      end else if (ext_rise) begin
         edge_cnt <= edge_cnt + 32'd1;
      end
   end

   // sticky change flag, held clear while the monitor is off
   always_ff @(posedge clk_usb) begin
      if (reset)
         change_q <= 1'b0;
      else if (monitor_disable_i)
         change_q <= 1'b0;
      else if (tb_i.gate_pulse && over_limit)
         change_q <= 1'b1;
   end

   assign stat_o.frequency = freq_q;
   assign stat_o.change    = change_q;
   assign stat_o.clk_level = ext_sync;

endmodule

`default_nettype wire

// ==== source/oadc_timebase.sv ====
`default_nettype none

module oadc_timebase #(
   parameter int P_GATE_LOG2 = 23
)(
   input  wire                 clk_usb,
   input  wire                 reset,
   output oadc_pkg::timebase_t tb_o
);

   localparam int CNT_W = P_GATE_LOG2 + 3;

   logic [CNT_W-1:0] hb_cnt;         // free-running heartbeat counter
   logic             gate_bit_q;     // gate bit delayed by one cycle
   logic             gate_pulse_q;
   logic             flash_q;

   // the gate window closes each time the low P_GATE_LOG2 bits roll over,
   // which drops bit P_GATE_LOG2-1; the registered copy catches that step
   // so the first pulse lands one window plus one cycle after reset
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         hb_cnt       <= '0;
         gate_bit_q   <= 1'b0;
         gate_pulse_q <= 1'b0;
         flash_q      <= 1'b0;
      end else begin
         hb_cnt       <= hb_cnt + CNT_W'(1);
         gate_bit_q   <= hb_cnt[P_GATE_LOG2-1];
         gate_pulse_q <= gate_bit_q & ~hb_cnt[P_GATE_LOG2-1];
         flash_q      <= hb_cnt[CNT_W-1] & hb_cnt[CNT_W-2];   // short blink per period
      end
   end

   assign tb_o.gate_pulse = gate_pulse_q;
   assign tb_o.heartbeat  = hb_cnt[P_GATE_LOG2+1];   // toggles every two windows
   assign tb_o.flash      = flash_q;

endmodule

`default_nettype wire

// ==== source/oadc_pkg.sv ====
`default_nettype none

package oadc_pkg;

   // widths that carry a meaning
   typedef logic [7:0]  reg_addr_t;
   typedef logic [7:0]  reg_byte_t;
   typedef logic [6:0]  reg_bytecnt_t;   // byte index inside a multi-byte register
   typedef logic [31:0] freq_count_t;    // target clock edges per gate window
   typedef logic [7:0]  gain_t;          // PWM increment

   // LED source select
   typedef enum logic [1:0] {
      led_normal = 2'd0,   // heartbeat on armed, change flag on capture
      led_extclk = 2'd1,   // synchronised target clock level on both
      led_off    = 2'd2,
      led_on     = 2'd3    // lamp test
   } led_sel_e;

   // one host bus request, driven every cycle
   typedef struct packed {
      reg_addr_t    address;
      reg_bytecnt_t bytecnt;
      reg_byte_t    data;
      logic         read;
      logic         write;
   } reg_bus_t;

   typedef struct packed {
      logic gate_pulse;    // one cycle per gate window
      logic heartbeat;
      logic flash;
   } timebase_t;

   typedef struct packed {
      freq_count_t frequency;   // edges counted in the last full window
      logic        change;      // sticky
      logic        clk_level;
   } extclk_stat_t;

   // register map
   localparam reg_addr_t ADDR_LED_SELECT   = 8'h10;
   localparam reg_addr_t ADDR_GAIN         = 8'h11;
   localparam reg_addr_t ADDR_EXTCLK_LIMIT = 8'h12;
   localparam reg_addr_t ADDR_EXTCLK_FREQ  = 8'h13;   // read only
   localparam reg_addr_t ADDR_STATUS       = 8'h14;   // read only

endpackage

`default_nettype wire
